//--- boot.hex
// boot rom, one 32-bit hex word per line, word 0 first
00000093
00100113
00208193
10000237
00022283
00128293
00522023
fe5ff06f
deadbeef
0badf00d
13579bdf
2468ace0
5a5aa5a5
c001d00d
7e57c0de
f00dface

//--- sim.f
soc_pkg.sv
ram_arbiter.sv
ibus_router.sv
dbus_decoder.sv
gpio_port.sv
tick_timer.sv
soc_toplevel.sv
tb_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_soc -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_soc > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
    exit 1
fi
exit 0

//--- tb_soc.sv
`timescale 1ns/1ns

module tb_soc;
    import soc_pkg::*;

    localparam int RAM_AW        = 8;
    localparam int ROM_AW        = 4;
    localparam int TICK_PRESCALE = 4;
    localparam int RAM_WORDS     = 2**RAM_AW;
    localparam int N_BE          = 48;
    localparam int N_CONC_D      = 96;
    localparam int N_CONC_I      = 96;
    localparam int GPIO_XFERS    = 11;
    localparam int TICK_XFERS    = 9;
    localparam int DBUS_XFERS    = 2 * RAM_WORDS + 2 * N_BE + N_CONC_D + GPIO_XFERS + TICK_XFERS;
    localparam int MAX_CYCLES    = (DBUS_XFERS + N_CONC_I) * 6 + 500;
    localparam int TICK_WAIT     = (3 + 1) * TICK_PRESCALE + 4;

    logic             clk_i;
    logic             arst_n_i;
    bus_req_t         ibus_req;
    bus_rsp_t         ibus_rsp;
    bus_req_t         dbus_req;
    bus_rsp_t         dbus_rsp;
    data_t            gpio_in;
    data_t            gpio_out;
    logic [IRQ_W-1:0] irq;

    data_t      ram_model [RAM_WORDS];
    data_t      rom_model [2**ROM_AW];
    data_t      gpio_model;
    integer     seed;
    int         errors;
    int         checks;
    int         cycles;
    int         i_done;
    int         d_done;
    addr_t      d_addr  [N_CONC_D];
    data_t      d_wdata [N_CONC_D];
    be_t        d_be    [N_CONC_D];
    logic [1:0] d_kind  [N_CONC_D];   // bit 0 read, bit 1 unmapped
    addr_t      i_addr  [N_CONC_I];

    soc_toplevel #(
        .RAM_AW        (RAM_AW),
        .ROM_AW        (ROM_AW),
        .TICK_PRESCALE (TICK_PRESCALE)
    ) soc_toplevel_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .ibus_req_i (ibus_req),
        .ibus_rsp_o (ibus_rsp),
        .dbus_req_i (dbus_req),
        .dbus_rsp_o (dbus_rsp),
        .gpio_i     (gpio_in),
        .gpio_o     (gpio_out),
        .irq_o      (irq)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, ibus %0d of %0d and dbus %0d of %0d transfers done",
                     cycles, i_done, N_CONC_I, d_done, DBUS_XFERS);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic data_t rand_word();
        return $random(seed);
    endfunction

    function automatic data_t fill_pattern(addr_t a);
        return {a[15:0], a[31:16]} ^ (a << 3) ^ 32'h3c5a_96e1;
    endfunction

    function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t be);
        data_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // top nibble that no slave of the given bus decodes
    function automatic logic [3:0] unmapped_nibble(logic ibus_side);
        data_t      r;
        logic [3:0] nib;
        r   = rand_word();
        nib = r[31:28];
        while (ibus_side ? (nib == 4'h1 || nib == 4'h8)
                         : (nib == 4'h8 || nib == 4'ha || nib == 4'hb)) begin
            r   = rand_word();
            nib = r[31:28];
        end
        return nib;
    endfunction

    function automatic data_t model_read(addr_t a, logic ibus_side);
        case (a[31:28])
            4'h8:    return ram_model[a[RAM_AW+1:2]];
            4'h1:    return ibus_side ? rom_model[a[ROM_AW+1:2]] : 32'h0;
            default: return 32'h0;
        endcase
    endfunction

    task automatic check_word(input string name, input data_t exp, input data_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the completing edge
    task automatic dbus_xfer(input addr_t addr, input data_t wdata, input be_t be,
                             input logic wr, output data_t rdata);
        dbus_req.addr  = addr;
        dbus_req.wdata = wdata;
        dbus_req.be    = be;
        dbus_req.read  = ~wr;
        dbus_req.write = wr;
        @(negedge clk_i);
        while (dbus_rsp.stall) @(negedge clk_i);   // request held while stalled
        rdata = dbus_rsp.rdata;
        @(posedge clk_i);
        #1;
        dbus_req.read  = 1'b0;
        dbus_req.write = 1'b0;
        d_done++;
    endtask

    task automatic ibus_read(input addr_t addr, output data_t rdata);
        ibus_req.addr = addr;
        ibus_req.read = 1'b1;
        @(negedge clk_i);
        while (ibus_rsp.stall) @(negedge clk_i);
        rdata = ibus_rsp.rdata;
        @(posedge clk_i);
        #1;
        ibus_req.read = 1'b0;
        i_done++;
    endtask

    task automatic fill_ram();
        addr_t a;
        data_t rd;
        for (int w = 0; w < RAM_WORDS; w++) begin
            a = 32'h8000_0000 | addr_t'(w << 2);
            dbus_xfer(a, fill_pattern(a), 4'hf, 1'b1, rd);
            ram_model[w] = fill_pattern(a);
        end
    endtask

    task automatic ram_be_test();
        data_t r;
        data_t wd;
        data_t rd;
        int    written [N_BE];
        for (int k = 0; k < N_BE; k++) begin
            r          = rand_word();
            wd         = rand_word();
            written[k] = int'(r[RAM_AW-2:0]);     // lower half only
            dbus_xfer(32'h8000_0000 | addr_t'(written[k] << 2), wd, r[11:8], 1'b1, rd);
            ram_model[written[k]] = merge_bytes(ram_model[written[k]], wd, r[11:8]);
        end
        for (int k = 0; k < N_BE; k++) begin
            dbus_xfer(32'h8000_0000 | addr_t'(written[k] << 2), '0, 4'hf, 1'b0, rd);
            check_word("ram_be_read", ram_model[written[k]], rd);
        end
    endtask

    task automatic concurrent_test();
        data_t r;
        data_t rd_i;
        data_t rd_d;
        int    w;
        for (int k = 0; k < N_CONC_D; k++) begin
            r          = rand_word();
            w          = int'(r[8:2]);
            d_kind[k]  = r[1:0];
            d_be[k]    = r[12:9];
            d_wdata[k] = rand_word();
            if (r[1]) d_addr[k] = {unmapped_nibble(1'b0), 28'h0} | addr_t'(w << 2);
            else d_addr[k] = 32'h8000_0000 | addr_t'(w << 2);
        end
        for (int k = 0; k < N_CONC_I; k++) begin
            r = rand_word();
            case (r[1:0])
                2'd0:    i_addr[k] = 32'h1000_0000 | addr_t'(int'(r[5:2]) << 2);
                2'd3:    i_addr[k] = {unmapped_nibble(1'b1), 28'h0} | addr_t'(int'(r[5:2]) << 2);
                default: i_addr[k] = 32'h8000_0000 | addr_t'((RAM_WORDS / 2 + int'(r[8:2])) << 2);
            endcase
        end
        fork
            begin
                for (int k = 0; k < N_CONC_I; k++) begin
                    ibus_read(i_addr[k], rd_i);
                    check_word("conc_ibus_read", model_read(i_addr[k], 1'b1), rd_i);
                end
            end
            begin
                for (int k = 0; k < N_CONC_D; k++) begin
                    if (d_kind[k][0]) begin
                        dbus_xfer(d_addr[k], '0, 4'hf, 1'b0, rd_d);
                        if (d_kind[k][1]) check_word("unmapped_read", 32'h0, rd_d);
                        else check_word("conc_dbus_read", model_read(d_addr[k], 1'b0), rd_d);
                    end else begin
                        dbus_xfer(d_addr[k], d_wdata[k], d_be[k], 1'b1, rd_d);
                        if (!d_kind[k][1]) begin
                            ram_model[d_addr[k][RAM_AW+1:2]] =
                                merge_bytes(ram_model[d_addr[k][RAM_AW+1:2]], d_wdata[k], d_be[k]);
                        end
                    end
                end
            end
        join
    endtask

    // unmapped writes must have left every word alone
    task automatic readback_test();
        data_t rd;
        for (int w = 0; w < RAM_WORDS; w++) begin
            dbus_xfer(32'h8000_0000 | addr_t'(w << 2), '0, 4'hf, 1'b0, rd);
            check_word("readback", ram_model[w], rd);
        end
    endtask

    task automatic gpio_test();
        data_t r;
        data_t rb;
        data_t rd;
        data_t new_in;
        logic  seen;
        for (int k = 0; k < 4; k++) begin
            r  = rand_word();
            rb = rand_word();
            dbus_xfer(32'ha000_0000, r, rb[3:0], 1'b1, rd);
            gpio_model = merge_bytes(gpio_model, r, rb[3:0]);
            check_word("gpio_o", gpio_model, gpio_out);
            dbus_xfer(32'ha000_0000, '0, 4'hf, 1'b0, rd);
            check_word("gpio_out_read", gpio_model, rd);
        end
        check_word("gpio_irq_idle", 32'h0, data_t'(irq[0]));
        r       = rand_word();
        new_in  = gpio_in ^ (r | 32'h1);     // at least one bit flips
        gpio_in = new_in;
        seen    = 1'b0;
        for (int k = 0; k < 4 && !seen; k++) begin
            @(posedge clk_i);
            #1;
            seen = irq[0];
        end
        checks++;
        assert (seen) else begin
            errors++;
            $display("gpio irq did not rise within 4 cycles of an input change");
        end
        dbus_xfer(32'ha000_0004, '0, 4'hf, 1'b0, rd);
        check_word("gpio_in", new_in, rd);
        dbus_xfer(32'ha000_0008, '0, 4'hf, 1'b0, rd);
        check_word("gpio_irq_read", 32'h1, rd);
        dbus_xfer(32'ha000_0008, '0, 4'hf, 1'b1, rd);
        check_word("gpio_irq_clear", 32'h0, data_t'(irq[0]));
    endtask

    task automatic timer_test();
        data_t rd;
        data_t prev;
        logic  seen;
        dbus_xfer(32'hb000_0004, '0, 4'hf, 1'b0, rd);
        check_word("tick_cmp_reset", 32'hffff_ffff, rd);
        dbus_xfer(32'hb000_0000, '0, 4'hf, 1'b0, prev);
        for (int k = 0; k < 4; k++) begin
            wait_cycles(3);
            dbus_xfer(32'hb000_0000, '0, 4'hf, 1'b0, rd);
            checks++;
            assert (rd >= prev) else begin
                errors++;
                $display("Fail tick_count: expected at least %h, actual %h", prev, rd);
            end
            prev = rd;
        end
        check_word("tick_irq_idle", 32'h0, data_t'(irq[1]));
        dbus_xfer(32'hb000_0004, prev + 32'd3, 4'hf, 1'b1, rd);
        seen = irq[1];
        for (int k = 0; k < TICK_WAIT && !seen; k++) begin
            @(posedge clk_i);
            #1;
            seen = irq[1];
        end
        checks++;
        assert (seen) else begin
            errors++;
            $display("timer irq did not rise within %0d cycles of the compare write", TICK_WAIT);
        end
        dbus_xfer(32'hb000_0008, '0, 4'hf, 1'b0, rd);
        check_word("tick_flag_read", 32'h1, rd);
        dbus_xfer(32'hb000_0008, '0, 4'hf, 1'b1, rd);
        check_word("tick_irq_clear", 32'h0, data_t'(irq[1]));
    endtask

    initial begin
        clk_i      = 1'b0;
        arst_n_i   = 1'b0;
        ibus_req   = '0;
        dbus_req   = '0;
        gpio_in    = '0;
        gpio_model = '0;
        seed       = 32'h5b3a_c03a;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        i_done     = 0;
        d_done     = 0;
        $readmemh("boot.hex", rom_model);
        repeat (8) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        check_word("reset_stall", 32'h0, data_t'({ibus_rsp.stall, dbus_rsp.stall}));
        check_word("reset_irq", 32'h0, data_t'(irq));
        check_word("reset_gpio_o", 32'h0, gpio_out);
        fill_ram();
        ram_be_test();
        concurrent_test();
        readback_test();
        gpio_test();
        timer_test();
        $display("checks: %0d, errors: %0d, ibus transfers: %0d, dbus transfers: %0d",
                 checks, errors, i_done, d_done);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- soc_toplevel.sv
`timescale 1ns/1ns

module soc_toplevel #(
    parameter int RAM_AW        = 8,
    parameter int ROM_AW        = 4,
    parameter int TICK_PRESCALE = 4
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  soc_pkg::bus_req_t        ibus_req_i,
    output soc_pkg::bus_rsp_t        ibus_rsp_o,
    input  soc_pkg::bus_req_t        dbus_req_i,
    output soc_pkg::bus_rsp_t        dbus_rsp_o,
    input  soc_pkg::data_t           gpio_i,
    output soc_pkg::data_t           gpio_o,
    output logic [soc_pkg::IRQ_W-1:0] irq_o
);
    import soc_pkg::*;

    bus_req_t iram_req;
    bus_rsp_t iram_rsp;
    bus_req_t dram_req;
    bus_rsp_t dram_rsp;
    bus_req_t gpio_req;
    bus_req_t tick_req;
    data_t    gpio_rdata;
    data_t    tick_rdata;
    logic     gpio_irq;
    logic     tick_irq;

    ibus_router #(.ROM_AW(ROM_AW)) ibus_router_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .ibus_req_i (ibus_req_i),
        .ibus_rsp_o (ibus_rsp_o),
        .ram_req_o  (iram_req),
        .ram_rsp_i  (iram_rsp)
    );

    dbus_decoder #(.RAM_AW(RAM_AW)) dbus_decoder_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .dbus_req_i   (dbus_req_i),
        .dbus_rsp_o   (dbus_rsp_o),
        .ram_req_o    (dram_req),
        .ram_rsp_i    (dram_rsp),
        .gpio_req_o   (gpio_req),
        .gpio_rdata_i (gpio_rdata),
        .tick_req_o   (tick_req),
        .tick_rdata_i (tick_rdata)
    );

    ram_arbiter #(.RAM_AW(RAM_AW)) ram_arbiter_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .ireq_i   (iram_req),
        .irsp_o   (iram_rsp),
        .dreq_i   (dram_req),
        .drsp_o   (dram_rsp)
    );

    gpio_port gpio_port_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (gpio_req),
        .rdata_o  (gpio_rdata),
        .gpio_i   (gpio_i),
        .gpio_o   (gpio_o),
        .irq_o    (gpio_irq)
    );

    tick_timer #(.TICK_PRESCALE(TICK_PRESCALE)) tick_timer_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (tick_req),
        .rdata_o  (tick_rdata),
        .irq_o    (tick_irq)
    );

    assign irq_o = {tick_irq, gpio_irq};   // bit 0 gpio, bit 1 timer

endmodule

//--- tick_timer.sv
`timescale 1ns/1ns

module tick_timer #(
    parameter int TICK_PRESCALE = 4
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::data_t    rdata_o,
    output logic              irq_o
);
    import soc_pkg::*;

    localparam int PW = (TICK_PRESCALE > 1) ? $clog2(TICK_PRESCALE) : 1;

    logic [PW-1:0] presc_q;
    data_t         count_q;
    data_t         cmp_q;
    logic          flag_q;
    logic          advance;
    logic          match;
    logic [1:0]    offset;

    assign offset  = reg_offset(req_i.addr);
    assign advance = (presc_q == PW'(TICK_PRESCALE - 1));
    assign match   = advance & (count_q == cmp_q);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            presc_q <= '0;
            count_q <= '0;
            cmp_q   <= '1;
            flag_q  <= 1'b0;
        end else begin
            presc_q <= advance ? '0 : presc_q + 1'b1;
            if (req_i.write && offset == 2'd0) begin
                count_q <= req_i.wdata;        // software load wins over a tick
            end else if (advance) begin
                count_q <= count_q + 1'b1;
            end
            if (req_i.write && offset == 2'd1) cmp_q <= req_i.wdata;
            if (match) begin
                flag_q <= 1'b1;
            end else if (req_i.write && offset == 2'd2) begin
                flag_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (offset)
            2'd0:    rdata_o = count_q;
            2'd1:    rdata_o = cmp_q;
            2'd2:    rdata_o = data_t'(flag_q);
            default: rdata_o = '0;
        endcase
    end

    assign irq_o = flag_q;

    a_flag_cause: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $rose(flag_q) |-> $past(match)
    );

endmodule

//--- gpio_port.sv
`timescale 1ns/1ns

module gpio_port (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::data_t    rdata_o,
    input  soc_pkg::data_t    gpio_i,
    output soc_pkg::data_t    gpio_o,
    output logic              irq_o
);
    import soc_pkg::*;

    data_t      out_q;
    data_t      sync1_q;
    data_t      sync2_q;
    data_t      prev_q;                    // last synchronized value
    logic       irq_q;
    logic [1:0] offset;

    assign offset = reg_offset(req_i.addr);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q   <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
            irq_q   <= 1'b0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            if (req_i.write && offset == 2'd0) out_q <= be_merge(out_q, req_i.wdata, req_i.be);
            if (sync2_q != prev_q) begin
                irq_q <= 1'b1;                 // a new edge beats a clear
            end else if (req_i.write && offset == 2'd2) begin
                irq_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (offset)
            2'd0:    rdata_o = out_q;
            2'd1:    rdata_o = sync2_q;
            2'd2:    rdata_o = data_t'(irq_q);
            default: rdata_o = '0;
        endcase
    end

    assign gpio_o = out_q;
    assign irq_o  = irq_q;

endmodule

//--- dbus_decoder.sv
`timescale 1ns/1ns

module dbus_decoder #(
    parameter int RAM_AW = 8
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  soc_pkg::bus_req_t dbus_req_i,
    output soc_pkg::bus_rsp_t dbus_rsp_o,
    output soc_pkg::bus_req_t ram_req_o,
    input  soc_pkg::bus_rsp_t ram_rsp_i,
    output soc_pkg::bus_req_t gpio_req_o,
    input  soc_pkg::data_t    gpio_rdata_i,
    output soc_pkg::bus_req_t tick_req_o,
    input  soc_pkg::data_t    tick_rdata_i
);
    import soc_pkg::*;

    region_e region;
    logic    ram_hit;
    logic    gpio_hit;
    logic    tick_hit;

    assign region   = region_of(dbus_req_i.addr);
    assign ram_hit  = (region == REGION_RAM);
    assign gpio_hit = (region == REGION_GPIO);
    assign tick_hit = (region == REGION_TICK);

    // strobes reach one slave only
    always_comb begin
        ram_req_o       = dbus_req_i;
        ram_req_o.addr  = addr_t'(dbus_req_i.addr[RAM_AW+1:0]); // offset inside the ram
        ram_req_o.read  = dbus_req_i.read & ram_hit;
        ram_req_o.write = dbus_req_i.write & ram_hit;

        gpio_req_o       = dbus_req_i;
        gpio_req_o.read  = dbus_req_i.read & gpio_hit;
        gpio_req_o.write = dbus_req_i.write & gpio_hit;

        tick_req_o       = dbus_req_i;
        tick_req_o.read  = dbus_req_i.read & tick_hit;
        tick_req_o.write = dbus_req_i.write & tick_hit;
    end

    always_comb begin
        dbus_rsp_o = '0;                 // unmapped accesses see no stall and zero data
        case (region)
            REGION_RAM:  dbus_rsp_o = ram_rsp_i;
            REGION_GPIO: dbus_rsp_o.rdata = gpio_rdata_i;
            REGION_TICK: dbus_rsp_o.rdata = tick_rdata_i;
            default:     dbus_rsp_o = '0;
        endcase
    end

    a_rd_wr_excl: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(dbus_req_i.read && dbus_req_i.write)
    );

    // a stalled master keeps its request until the slave lets it go
    a_hold_on_stall: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (dbus_req_i.read || dbus_req_i.write) && dbus_rsp_o.stall |=> $stable(dbus_req_i)
    );

endmodule

//--- ibus_router.sv
`timescale 1ns/1ns

module ibus_router #(
    parameter int ROM_AW = 4
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  soc_pkg::bus_req_t ibus_req_i,
    output soc_pkg::bus_rsp_t ibus_rsp_o,
    output soc_pkg::bus_req_t ram_req_o,
    input  soc_pkg::bus_rsp_t ram_rsp_i
);
    import soc_pkg::*;

    data_t   rom [2**ROM_AW];
    data_t   rom_q;
    logic    rom_pend_q;
    logic    rom_rd;
    region_e region;

    initial begin
        $readmemh("boot.hex", rom);
    end

    assign region = region_of(ibus_req_i.addr);
    assign rom_rd = (region == REGION_ROM) & ibus_req_i.read;

    // read register gives the rom the same two cycle read as the ram
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_pend_q <= 1'b0;
        end else begin
            rom_pend_q <= rom_rd & ~rom_pend_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rom_rd && !rom_pend_q) rom_q <= rom[ibus_req_i.addr[ROM_AW+1:2]];
    end

    always_comb begin
        ram_req_o       = ibus_req_i;
        ram_req_o.read  = (region == REGION_RAM) & ibus_req_i.read;
        ram_req_o.write = 1'b0;                // instruction side never writes
    end

    always_comb begin
        case (region)
            REGION_RAM: ibus_rsp_o = ram_rsp_i;
            REGION_ROM: begin
                ibus_rsp_o.rdata = rom_q;
                ibus_rsp_o.stall = rom_rd & ~rom_pend_q;
            end
            default: ibus_rsp_o = '0;          // unmapped reads give zero
        endcase
    end

endmodule

//--- ram_arbiter.sv
`timescale 1ns/1ns

module ram_arbiter #(
    parameter int RAM_AW = 8
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  soc_pkg::bus_req_t ireq_i,
    output soc_pkg::bus_rsp_t irsp_o,
    input  soc_pkg::bus_req_t dreq_i,
    output soc_pkg::bus_rsp_t drsp_o
);
    import soc_pkg::*;

    data_t             mem [2**RAM_AW];
    data_t             rdata_q;         // shared by both ports as only one is granted per cycle
    logic              ipend_q;
    logic              dpend_q;
    logic              dnext_q;         // dbus wins the next conflict
    logic              ivalid;
    logic              dvalid;
    logic              igrant;
    logic              dgrant;
    bus_req_t          sel;
    logic [RAM_AW-1:0] widx;

    // a port returning read data is not a new request
    assign ivalid = (ireq_i.read | ireq_i.write) & ~ipend_q;
    assign dvalid = (dreq_i.read | dreq_i.write) & ~dpend_q;

    assign igrant = ivalid & (~dvalid | ~dnext_q);
    assign dgrant = dvalid & (~ivalid | dnext_q);

    assign sel  = dgrant ? dreq_i : ireq_i;
    assign widx = sel.addr[RAM_AW+1:2];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ipend_q <= 1'b0;
            dpend_q <= 1'b0;
            dnext_q <= 1'b1;
        end else begin
            ipend_q <= igrant & ireq_i.read;
            dpend_q <= dgrant & dreq_i.read;
            if (ivalid && dvalid) dnext_q <= ~dnext_q; // alternate on conflict
        end
    end

    always_ff @(posedge clk_i) begin
        if ((igrant || dgrant) && sel.write) begin
            mem[widx] <= be_merge(mem[widx], sel.wdata, sel.be);
        end
        if ((igrant || dgrant) && sel.read) begin
            rdata_q <= mem[widx];
        end
    end

    // a write is done in its grant cycle and a read in the cycle after
    assign irsp_o.rdata = rdata_q;
    assign irsp_o.stall = ivalid & ~(igrant & ireq_i.write);
    assign drsp_o.rdata = rdata_q;
    assign drsp_o.stall = dvalid & ~(dgrant & dreq_i.write);

    // the array has a single access port
    a_one_grant: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(igrant && dgrant)
    );

endmodule

//--- soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;      // one bit per byte lane of data_t

    localparam int IRQ_W = 2;       // bit 0 gpio, bit 1 timer

    // master to slave request that stays stable while stall is high
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        be_t   be;
        logic  read;
        logic  write;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        logic  stall;
    } bus_rsp_t;

    // selected by addr[31:28] with all other codes unmapped
    typedef enum logic [3:0] {
        REGION_ROM  = 4'd1,
        REGION_RAM  = 4'd8,
        REGION_GPIO = 4'd10,
        REGION_TICK = 4'd11
    } region_e;

    function automatic region_e region_of(addr_t addr);
        return region_e'(addr[31:28]);
    endfunction

    // register offset inside a peripheral, word aligned
    function automatic logic [1:0] reg_offset(addr_t addr);
        return addr[3:2];
    endfunction

    function automatic data_t be_merge(data_t old_word, data_t new_word, be_t be);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

endpackage
